// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_simt_core -Mdir obj_dir -f src.f
	./obj_dir/Vtb_simt_core

clean:
	rm -rf obj_dir

// File: sim/simt_core_chk.sv
// bound assertions on retire latency and on pause and transfer timing, bound into the pipe and the transfer unit
module simt_core_chk (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input simt_pkg::warp_id_t issue_warp,
	input simt_pkg::pc_t issue_pc,
	input logic retire_valid,
	input simt_pkg::warp_id_t retire_warp,
	input simt_pkg::pc_t retire_pc,
	input logic no_pending_instructions,
	input logic pause_scheduling,
	input logic irq_pending,
	input logic xfer_valid,
	input logic xfer_none
);
	import simt_pkg::*;

	// a warp issued three edges ago leaves the pipe now with its own tag and PC
	assert property (@(posedge clk) disable iff (reset)
		$past(issue_valid, 3) |-> retire_valid && retire_warp == $past(issue_warp, 3)
			&& retire_pc == $past(issue_pc, 3))
		else $error("retire does not match the issue three cycles earlier");

	// nothing retires that was not issued
	assert property (@(posedge clk) disable iff (reset)
		retire_valid |-> $past(issue_valid, 3))
		else $error("retire without a matching issue");

	// the scheduler is only held in answer to a pending request
	assert property (@(posedge clk) disable iff (reset)
		$rose(pause_scheduling) |-> $past(irq_pending))
		else $error("pause raised without a pending interrupt");

	// the handoff outcome needs a drained pipe and the scheduler still held
	assert property (@(posedge clk) disable iff (reset)
		(xfer_valid || xfer_none) |-> $past(no_pending_instructions) && pause_scheduling)
		else $error("handoff outcome before the pipe drained");

	// with no warp to hand over the unit goes back to idle and scheduling resumes
	assert property (@(posedge clk) disable iff (reset)
		xfer_none |=> !pause_scheduling)
		else $error("pause still high one cycle after xfer_none");

	// the offer is a single-cycle pulse
	assert property (@(posedge clk) disable iff (reset)
		xfer_valid |=> !xfer_valid)
		else $error("xfer_valid longer than one cycle");

endmodule

// File: sim/tb_simt_core.sv
// self-checking testbench for the SIMT core top level, random stimulus against a cycle model
module tb_simt_core;
	import simt_pkg::*;

	localparam int clk_period = 10;
	localparam int reset_cycles = 3;
	localparam int num_cycles = 4000;
	// slack for the last cycles of the run
	localparam int margin_time = 500;

	logic clk;
	logic reset;
	logic launch;
	warp_id_t launch_warp;
	pc_t launch_pc;
	thread_mask_t launch_mask;
	logic barrier_arrive;
	warp_id_t barrier_warp;
	logic barrier_release;
	logic diverge;
	logic reconverge;
	warp_id_t div_warp;
	logic cfg_we;
	logic cfg_irq_enable;
	logic irq;
	logic isr_done;

	logic issue_valid;
	warp_id_t issue_warp;
	pc_t issue_pc;
	logic retire_valid;
	warp_id_t retire_warp;
	pc_t retire_pc;
	logic pause_scheduling;
	logic xfer_valid;
	warp_id_t xfer_warp;
	pc_t xfer_pc;
	thread_mask_t xfer_mask;
	logic xfer_none;
	irq_count_t irq_count;

	integer seed = 33;

	// model of the warp slots
	pc_t m_pc [num_warps];
	thread_mask_t m_mask [num_warps];
	depth_t m_depth [num_warps];
	warp_mask_t m_active;
	warp_mask_t m_barrier;
	warp_id_t m_last;

	// model of the issue register and the three pipe stages
	logic m_iv;
	warp_id_t m_iw;
	pc_t m_ipc;
	logic [pipe_depth-1:0] m_pv;
	warp_id_t m_pw [pipe_depth];
	pc_t m_ppc [pipe_depth];

	// model of the interrupt controller and the transfer FSM
	logic m_en;
	logic m_pend;
	irq_count_t m_count;
	ttu_state_t m_state;
	logic m_xv;
	logic m_xn;
	warp_id_t m_xw;
	pc_t m_xpc;
	thread_mask_t m_xmask;

	// a transferred warp must come back at the PC it was handed out with
	logic resume_armed = 1'b0;
	warp_id_t resume_warp;
	pc_t resume_pc;
	int n_xfer = 0;
	int n_none = 0;

	simt_core_top i_dut (
		.clk              (clk),
		.reset            (reset),
		.launch           (launch),
		.launch_warp      (launch_warp),
		.launch_pc        (launch_pc),
		.launch_mask      (launch_mask),
		.barrier_arrive   (barrier_arrive),
		.barrier_warp     (barrier_warp),
		.barrier_release  (barrier_release),
		.diverge          (diverge),
		.reconverge       (reconverge),
		.div_warp         (div_warp),
		.cfg_we           (cfg_we),
		.cfg_irq_enable   (cfg_irq_enable),
		.irq              (irq),
		.isr_done         (isr_done),
		.issue_valid      (issue_valid),
		.issue_warp       (issue_warp),
		.issue_pc         (issue_pc),
		.retire_valid     (retire_valid),
		.retire_warp      (retire_warp),
		.retire_pc        (retire_pc),
		.pause_scheduling (pause_scheduling),
		.xfer_valid       (xfer_valid),
		.xfer_warp        (xfer_warp),
		.xfer_pc          (xfer_pc),
		.xfer_mask        (xfer_mask),
		.xfer_none        (xfer_none),
		.irq_count        (irq_count)
	);

	// the pipe instance checks retire latency, the transfer side is tied off there
	bind issue_pipe simt_core_chk i_pipe_chk (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .issue_warp(issue_warp), .issue_pc(issue_pc),
		.retire_valid(retire_valid), .retire_warp(retire_warp), .retire_pc(retire_pc),
		.no_pending_instructions(no_pending_instructions),
		.pause_scheduling(1'b0), .irq_pending(1'b0), .xfer_valid(1'b0), .xfer_none(1'b0)
	);

	// the transfer unit instance checks pause and handoff, the pipe side is tied off
	bind thread_transfer_unit simt_core_chk i_ttu_chk (
		.clk(clk), .reset(reset),
		.issue_valid(1'b0), .issue_warp('0), .issue_pc('0),
		.retire_valid(1'b0), .retire_warp('0), .retire_pc('0),
		.no_pending_instructions(no_pending_instructions),
		.pause_scheduling(pause_scheduling), .irq_pending(irq_pending),
		.xfer_valid(xfer_valid), .xfer_none(xfer_none)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic report_mismatch(input string msg);
		$display("error at time %0t: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_issue(input logic exp_valid, input warp_id_t exp_warp, input pc_t exp_pc);
		if (issue_valid !== exp_valid) begin
			report_mismatch($sformatf("issue_valid expected %0b got %0b", exp_valid, issue_valid));
		end else if (exp_valid && (issue_warp !== exp_warp || issue_pc !== exp_pc)) begin
			report_mismatch($sformatf("issue expected warp %0d pc %h got warp %0d pc %h",
				exp_warp, exp_pc, issue_warp, issue_pc));
		end
	endtask

	task automatic check_retire(input logic exp_valid, input warp_id_t exp_warp, input pc_t exp_pc);
		if (retire_valid !== exp_valid) begin
			report_mismatch($sformatf("retire_valid expected %0b got %0b", exp_valid, retire_valid));
		end else if (exp_valid && (retire_warp !== exp_warp || retire_pc !== exp_pc)) begin
			report_mismatch($sformatf("retire expected warp %0d pc %h got warp %0d pc %h",
				exp_warp, exp_pc, retire_warp, retire_pc));
		end
	endtask

	task automatic check_xfer(input logic exp_pause, input logic exp_valid, input logic exp_none,
		input warp_id_t exp_warp, input pc_t exp_pc, input thread_mask_t exp_mask);
		if (pause_scheduling !== exp_pause) begin
			report_mismatch($sformatf("pause expected %0b got %0b", exp_pause, pause_scheduling));
		end else if (xfer_valid !== exp_valid || xfer_none !== exp_none) begin
			report_mismatch($sformatf("xfer_valid/xfer_none expected %0b%0b got %0b%0b",
				exp_valid, exp_none, xfer_valid, xfer_none));
		end else if (exp_valid && (xfer_warp !== exp_warp || xfer_pc !== exp_pc
			|| xfer_mask !== exp_mask)) begin
			report_mismatch($sformatf("xfer expected warp %0d pc %h mask %b got %0d %h %b",
				exp_warp, exp_pc, exp_mask, xfer_warp, xfer_pc, xfer_mask));
		end
	endtask

	task automatic check_count(input irq_count_t exp_count);
		if (irq_count !== exp_count) begin
			report_mismatch($sformatf("irq_count expected %0d got %0d", exp_count, irq_count));
		end
	endtask

	task automatic reset_model();
		m_active = '0;
		m_barrier = '0;
		for (int i = 0; i < num_warps; i++) begin
			m_depth[i] = 3'd0;
		end
		// the first search after reset starts at warp 0
		m_last = warp_id_t'(num_warps - 1);
		m_iv = 1'b0;
		m_pv = '0;
		m_en = 1'b0;
		m_pend = 1'b0;
		m_count = '0;
		m_state = idle;
		m_xv = 1'b0;
		m_xn = 1'b0;
	endtask

	// advance the model by one clock edge using the inputs sampled at that edge
	task automatic step_model();
		warp_mask_t runnable;
		warp_mask_t movable;
		warp_id_t cand;
		warp_id_t pick;
		warp_id_t lowest;
		logic found;
		logic any_movable;
		logic empty;
		logic fire;
		logic finished;
		logic taken;
		logic drained;
		ttu_state_t nxt;
		empty = !m_iv && (m_pv == '0);
		runnable = m_active & ~m_barrier;
		for (int i = 0; i < num_warps; i++) begin
			movable[i] = runnable[i] && (m_depth[i] == 3'd0);
		end
		found = 1'b0;
		pick = '0;
		for (int i = 0; i < num_warps; i++) begin
			cand = warp_id_t'((int'(m_last) + 1 + i) % num_warps);
			if (!found && runnable[cand]) begin
				pick = cand;
				found = 1'b1;
			end
		end
		any_movable = 1'b0;
		lowest = '0;
		for (int i = 0; i < num_warps; i++) begin
			if (!any_movable && movable[i]) begin
				lowest = warp_id_t'(i);
				any_movable = 1'b1;
			end
		end
		fire = found && (m_state == idle);
		finished = (m_state == wait_isr) && isr_done;
		taken = finished || ((m_state == handoff) && m_xn);
		drained = (m_state == drain) && empty;
		nxt = m_state;
		case (m_state)
			idle: if (m_pend) nxt = drain;
			drain: if (empty) nxt = handoff;
			handoff: nxt = m_xv ? wait_isr : idle;
			default: if (isr_done) nxt = idle;
		endcase
		m_state = nxt;
		m_xv = drained && any_movable;
		m_xn = drained && !any_movable;
		if (m_xv) begin
			m_xw = lowest;
			m_xpc = m_pc[lowest];
			m_xmask = m_mask[lowest];
		end
		if (taken) begin
			m_pend = 1'b0;
		end else if (irq && m_en) begin
			m_pend = 1'b1;
		end
		if (cfg_we) m_en = cfg_irq_enable;
		if (finished) m_count = m_count + 16'd1;
		for (int i = pipe_depth - 1; i > 0; i--) begin
			m_pv[i] = m_pv[i-1];
			m_pw[i] = m_pw[i-1];
			m_ppc[i] = m_ppc[i-1];
		end
		m_pv[0] = m_iv;
		m_pw[0] = m_iw;
		m_ppc[0] = m_ipc;
		m_iv = fire;
		if (fire) begin
			m_iw = pick;
			m_ipc = m_pc[pick];
			m_last = pick;
			m_pc[pick] = m_pc[pick] + 32'd4;
		end
		if (barrier_release) m_barrier = '0;
		if (barrier_arrive) m_barrier[barrier_warp] = 1'b1;
		if (diverge && !reconverge && m_depth[div_warp] != 3'd7) begin
			m_depth[div_warp] = m_depth[div_warp] + 3'd1;
		end else if (reconverge && !diverge && m_depth[div_warp] != 3'd0) begin
			m_depth[div_warp] = m_depth[div_warp] - 3'd1;
		end
		// a launch overrides everything else on its slot
		if (launch) begin
			m_pc[launch_warp] = launch_pc;
			m_mask[launch_warp] = launch_mask;
			m_active[launch_warp] = 1'b1;
			m_barrier[launch_warp] = 1'b0;
			m_depth[launch_warp] = 3'd0;
		end
	endtask

	// launches are held back while a transfer runs so a paused warp keeps its PC
	task automatic drive_stimulus();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		r = $random(seed);
		a = $random(seed);
		b = $random(seed);
		launch <= (m_state == idle) && (r[4:0] == 5'd0);
		launch_warp <= r[6:5];
		launch_pc <= {a[31:2], 2'b00};
		launch_mask <= r[10:7];
		barrier_arrive <= (r[14:11] == 4'd0);
		barrier_warp <= r[16:15];
		barrier_release <= (r[21:17] == 5'd0);
		diverge <= (r[24:22] == 3'd0);
		reconverge <= (r[27:25] == 3'd0);
		div_warp <= r[29:28];
		cfg_we <= (b[5:0] == 6'd0);
		cfg_irq_enable <= (b[7:6] != 2'b00);
		irq <= (b[12:8] == 5'd0);
		isr_done <= (b[15:13] == 3'd0);
	endtask

	always @(posedge clk) begin
		if (reset) begin
			reset_model();
		end else begin
			step_model();
			drive_stimulus();
		end
	end

	// outputs settle after the rising edge, so they are compared on the falling one
	always @(negedge clk) begin
		if (!reset) begin
			check_issue(m_iv, m_iw, m_ipc);
			check_retire(m_pv[pipe_depth-1], m_pw[pipe_depth-1], m_ppc[pipe_depth-1]);
			check_xfer(m_state != idle, m_xv, m_xn, m_xw, m_xpc, m_xmask);
			check_count(m_count);
			if (issue_valid && resume_armed && issue_warp == resume_warp) begin
				if (issue_pc !== resume_pc) begin
					report_mismatch($sformatf("warp %0d resumed at %h instead of %h",
						issue_warp, issue_pc, resume_pc));
				end
				resume_armed = 1'b0;
			end
			if (xfer_valid) begin
				resume_armed = 1'b1;
				resume_warp = xfer_warp;
				resume_pc = xfer_pc;
				n_xfer++;
			end
			if (xfer_none) n_none++;
			// a relaunch gives the warp a new PC
			if (launch && launch_warp == resume_warp) resume_armed = 1'b0;
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		launch = 1'b0;
		launch_warp = '0;
		launch_pc = '0;
		launch_mask = '0;
		barrier_arrive = 1'b0;
		barrier_warp = '0;
		barrier_release = 1'b0;
		diverge = 1'b0;
		reconverge = 1'b0;
		div_warp = '0;
		cfg_we = 1'b0;
		cfg_irq_enable = 1'b0;
		irq = 1'b0;
		isr_done = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		repeat (num_cycles) @(posedge clk);
		$display("warps transferred %0d, empty handoffs %0d", n_xfer, n_none);
		if (n_xfer == 0) begin
			$display("no warp was handed to the scalar core during the run");
			$display("STATUS: FAIL");
			$fatal(1, "transfer path never exercised");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

	// watchdog sized from the reset phase and the test length
	initial begin
		#((reset_cycles + num_cycles) * clk_period + margin_time);
		$display("timeout: the run did not end within the expected number of cycles");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: src.f
verilog/simt_pkg.sv
verilog/warp_table.sv
verilog/issue_pipe.sv
verilog/interrupt_ctl.sv
verilog/thread_transfer_unit.sv
verilog/simt_core_top.sv
sim/simt_core_chk.sv
sim/tb_simt_core.sv

// File: verilog/interrupt_ctl.sv
// interrupt controller with the enable register, the pending latch and the count of finished handlers
module interrupt_ctl (
	input logic clk,
	input logic reset,
	input logic cfg_we,
	input logic cfg_irq_enable,
	input logic irq,
	input logic irq_taken,
	input logic isr_finished,
	output logic irq_pending,
	output simt_pkg::irq_count_t irq_count
);
	import simt_pkg::*;

	// software enable, off after reset
	logic enable_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			enable_q <= 1'b0;
		end else if (cfg_we) begin
			enable_q <= cfg_irq_enable;
		end
	end

	// the request stays pending for the whole transfer, so repeated irqs fold into it
	// the transfer unit marks it taken on the edge where it goes back to idle
	// clearing wins over an irq in that same cycle, which is merged with the finished one
	always_ff @(posedge clk) begin
		if (reset) begin
			irq_pending <= 1'b0;
		end else if (irq_taken) begin
			irq_pending <= 1'b0;
		end else if (irq && enable_q) begin
			irq_pending <= 1'b1;
		end
	end

	// only handlers that actually ran are counted, a transfer with no warp is not
	always_ff @(posedge clk) begin
		if (reset) begin
			irq_count <= '0;
		end else if (isr_finished) begin
			irq_count <= irq_count + irq_count_t'(1);
		end
	end

endmodule

// File: verilog/issue_pipe.sv
// fixed-latency issue pipeline that retires warps and tells the transfer unit when it is empty
module issue_pipe (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input simt_pkg::warp_id_t issue_warp,
	input simt_pkg::pc_t issue_pc,
	output logic retire_valid,
	output simt_pkg::warp_id_t retire_warp,
	output simt_pkg::pc_t retire_pc,
	output logic no_pending_instructions
);
	import simt_pkg::*;

	// stage 0 is loaded from the issue register, the last stage retires
	logic [pipe_depth-1:0] valid_q;
	warp_id_t warp_q [pipe_depth];
	pc_t pc_q [pipe_depth];

	// the pipe never stalls, so every stage shifts on every edge
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[pipe_depth-2:0], issue_valid};
		end
	end

	// payload follows the valids without a reset of its own
	always_ff @(posedge clk) begin
		warp_q[0] <= issue_warp;
		pc_q[0] <= issue_pc;
		for (int i = 1; i < pipe_depth; i++) begin
			warp_q[i] <= warp_q[i-1];
			pc_q[i] <= pc_q[i-1];
		end
	end

	assign retire_valid = valid_q[pipe_depth-1];
	assign retire_warp = warp_q[pipe_depth-1];
	assign retire_pc = pc_q[pipe_depth-1];

	// a warp sitting in the issue register is about to enter stage 0, so it counts as pending
	assign no_pending_instructions = !(issue_valid || (|valid_q));

endmodule

// File: verilog/simt_core_top.sv
// top level of the SIMT scheduler with its thread transfer path, the DUT seen by the testbench
module simt_core_top (
	input logic clk,
	input logic reset,
	input logic launch,
	input simt_pkg::warp_id_t launch_warp,
	input simt_pkg::pc_t launch_pc,
	input simt_pkg::thread_mask_t launch_mask,
	input logic barrier_arrive,
	input simt_pkg::warp_id_t barrier_warp,
	input logic barrier_release,
	input logic diverge,
	input logic reconverge,
	input simt_pkg::warp_id_t div_warp,
	input logic cfg_we,
	input logic cfg_irq_enable,
	input logic irq,
	input logic isr_done,
	output logic issue_valid,
	output simt_pkg::warp_id_t issue_warp,
	output simt_pkg::pc_t issue_pc,
	output logic retire_valid,
	output simt_pkg::warp_id_t retire_warp,
	output simt_pkg::pc_t retire_pc,
	output logic pause_scheduling,
	output logic xfer_valid,
	output simt_pkg::warp_id_t xfer_warp,
	output simt_pkg::pc_t xfer_pc,
	output simt_pkg::thread_mask_t xfer_mask,
	output logic xfer_none,
	output simt_pkg::irq_count_t irq_count
);
	import simt_pkg::*;

	// interrupt controller and transfer unit handshake
	logic irq_pending;
	logic irq_taken;
	logic isr_finished;

	// warp state read by the transfer unit
	warp_mask_t warp_active;
	warp_mask_t warp_barriered;
	warp_mask_t warp_stack_empty;
	pc_t warp_pc [num_warps];
	thread_mask_t warp_mask [num_warps];

	logic no_pending_instructions;

	warp_table i_warp_table (
		.clk              (clk),
		.reset            (reset),
		.launch           (launch),
		.launch_warp      (launch_warp),
		.launch_pc        (launch_pc),
		.launch_mask      (launch_mask),
		.barrier_arrive   (barrier_arrive),
		.barrier_warp     (barrier_warp),
		.barrier_release  (barrier_release),
		.diverge          (diverge),
		.reconverge       (reconverge),
		.div_warp         (div_warp),
		.pause_scheduling (pause_scheduling),
		.issue_valid      (issue_valid),
		.issue_warp       (issue_warp),
		.issue_pc         (issue_pc),
		.warp_active      (warp_active),
		.warp_barriered   (warp_barriered),
		.warp_stack_empty (warp_stack_empty),
		.warp_pc          (warp_pc),
		.warp_mask        (warp_mask)
	);

	issue_pipe i_issue_pipe (
		.clk                     (clk),
		.reset                   (reset),
		.issue_valid             (issue_valid),
		.issue_warp              (issue_warp),
		.issue_pc                (issue_pc),
		.retire_valid            (retire_valid),
		.retire_warp             (retire_warp),
		.retire_pc               (retire_pc),
		.no_pending_instructions (no_pending_instructions)
	);

	interrupt_ctl i_interrupt_ctl (
		.clk            (clk),
		.reset          (reset),
		.cfg_we         (cfg_we),
		.cfg_irq_enable (cfg_irq_enable),
		.irq            (irq),
		.irq_taken      (irq_taken),
		.isr_finished   (isr_finished),
		.irq_pending    (irq_pending),
		.irq_count      (irq_count)
	);

	thread_transfer_unit i_thread_transfer_unit (
		.clk                     (clk),
		.reset                   (reset),
		.irq_pending             (irq_pending),
		.no_pending_instructions (no_pending_instructions),
		.isr_done                (isr_done),
		.warp_active             (warp_active),
		.warp_barriered          (warp_barriered),
		.warp_stack_empty        (warp_stack_empty),
		.warp_pc                 (warp_pc),
		.warp_mask               (warp_mask),
		.pause_scheduling        (pause_scheduling),
		.irq_taken               (irq_taken),
		.isr_finished            (isr_finished),
		.xfer_valid              (xfer_valid),
		.xfer_none               (xfer_none),
		.xfer_warp               (xfer_warp),
		.xfer_pc                 (xfer_pc),
		.xfer_mask               (xfer_mask)
	);

endmodule

// File: verilog/simt_pkg.sv
// shared sizes, vector types and the transfer FSM encoding, imported by every RTL block and the testbench
package simt_pkg;

	// number of warp slots held by the scheduler
	localparam int num_warps = 4;

	// threads per warp, one mask bit each
	localparam int num_threads = 4;

	// stages between issue and retire
	localparam int pipe_depth = 3;

	// program counter of a warp
	typedef logic [31:0] pc_t;

	// index of a warp slot
	typedef logic [1:0] warp_id_t;

	// one bit per warp slot, used for active, barrier and stack-empty flags
	typedef logic [num_warps-1:0] warp_mask_t;

	// one bit per thread of a warp
	typedef logic [num_threads-1:0] thread_mask_t;

	// depth of the reconvergence stack that stands in for a real ipdom stack
	typedef logic [2:0] depth_t;

	// number of interrupt handlers that have run to completion
	typedef logic [15:0] irq_count_t;

	// every instruction is one word, so a warp moves on by four bytes per issue
	localparam pc_t inst_bytes = 32'd4;

	// the depth counter stops here on diverge and at zero on reconverge
	localparam depth_t depth_max = 3'd7;

	// states of the thread transfer FSM
	// idle     scheduling runs and the unit waits for a pending interrupt
	// drain    scheduling is paused until the issue pipeline is empty
	// handoff  one cycle in which the selected warp is offered to the scalar core
	// wait_isr the scalar core runs its handler until isr_done comes back
	typedef enum logic [1:0] {
		idle,
		drain,
		handoff,
		wait_isr
	} ttu_state_t;

endpackage

// File: verilog/thread_transfer_unit.sv
// transfer FSM that pauses the scheduler, waits for drain and hands one warp to the scalar core
module thread_transfer_unit (
	input logic clk,
	input logic reset,
	input logic irq_pending,
	input logic no_pending_instructions,
	input logic isr_done,
	input simt_pkg::warp_mask_t warp_active,
	input simt_pkg::warp_mask_t warp_barriered,
	input simt_pkg::warp_mask_t warp_stack_empty,
	input simt_pkg::pc_t warp_pc [simt_pkg::num_warps],
	input simt_pkg::thread_mask_t warp_mask [simt_pkg::num_warps],
	output logic pause_scheduling,
	output logic irq_taken,
	output logic isr_finished,
	output logic xfer_valid,
	output logic xfer_none,
	output simt_pkg::warp_id_t xfer_warp,
	output simt_pkg::pc_t xfer_pc,
	output simt_pkg::thread_mask_t xfer_mask
);
	import simt_pkg::*;

	ttu_state_t state_q;
	ttu_state_t state_d;

	warp_mask_t eligible;
	warp_id_t sel;
	logic drained;

	// a warp can move to the scalar core only when it is converged and free to run
	assign eligible = warp_active & ~warp_barriered & warp_stack_empty;

	// priority search, the lowest index wins
	always_comb begin
		sel = '0;
		for (int i = num_warps - 1; i >= 0; i--) begin
			if (eligible[i]) begin
				sel = warp_id_t'(i);
			end
		end
	end

	assign drained = (state_q == drain) && no_pending_instructions;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			idle: begin
				if (irq_pending) begin
					state_d = drain;
				end
			end
			drain: begin
				if (no_pending_instructions) begin
					state_d = handoff;
				end
			end
			handoff: begin
				// xfer_valid already holds the outcome of the search
				state_d = xfer_valid ? wait_isr : idle;
			end
			wait_isr: begin
				if (isr_done) begin
					state_d = idle;
				end
			end
			default: begin
				state_d = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= idle;
		end else begin
			state_q <= state_d;
		end
	end

	// the outcome is registered at the end of drain so it shows during the handoff cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			xfer_valid <= 1'b0;
			xfer_none <= 1'b0;
		end else begin
			xfer_valid <= drained && (|eligible);
			xfer_none <= drained && !(|eligible);
		end
	end

	// the PC handed out is the one the warp will resume from, since issue is frozen here
	always_ff @(posedge clk) begin
		if (drained) begin
			xfer_warp <= sel;
			xfer_pc <= warp_pc[sel];
			xfer_mask <= warp_mask[sel];
		end
	end

	assign pause_scheduling = (state_q != idle);

	// handler completion is only accepted while waiting for it
	assign isr_finished = (state_q == wait_isr) && isr_done;

	// the request is consumed when the unit goes back to idle, with or without a handler
	assign irq_taken = isr_finished || ((state_q == handoff) && xfer_none);

endmodule

// File: verilog/warp_table.sv
// per-warp scheduler state with a round-robin issue selector, driven by the SIMT core top level
module warp_table (
	input logic clk,
	input logic reset,
	input logic launch,
	input simt_pkg::warp_id_t launch_warp,
	input simt_pkg::pc_t launch_pc,
	input simt_pkg::thread_mask_t launch_mask,
	input logic barrier_arrive,
	input simt_pkg::warp_id_t barrier_warp,
	input logic barrier_release,
	input logic diverge,
	input logic reconverge,
	input simt_pkg::warp_id_t div_warp,
	input logic pause_scheduling,
	output logic issue_valid,
	output simt_pkg::warp_id_t issue_warp,
	output simt_pkg::pc_t issue_pc,
	output simt_pkg::warp_mask_t warp_active,
	output simt_pkg::warp_mask_t warp_barriered,
	output simt_pkg::warp_mask_t warp_stack_empty,
	output simt_pkg::pc_t warp_pc [simt_pkg::num_warps],
	output simt_pkg::thread_mask_t warp_mask [simt_pkg::num_warps]
);
	import simt_pkg::*;

	// next PC and thread mask of every slot
	pc_t pc_q [num_warps];
	thread_mask_t mask_q [num_warps];

	// control flags, cleared by reset
	warp_mask_t active_q;
	warp_mask_t barrier_q;
	depth_t depth_q [num_warps];

	// slot that issued last, the search starts just after it
	warp_id_t last_q;

	warp_mask_t issuable;
	warp_mask_t launch_onehot;
	warp_mask_t arrive_onehot;
	warp_id_t sel;
	logic sel_found;
	logic issue_fire;

	// a warp may issue once launched unless it sits at a barrier
	assign issuable = active_q & ~barrier_q;

	assign launch_onehot = launch ? (warp_mask_t'(1) << launch_warp) : '0;
	assign arrive_onehot = barrier_arrive ? (warp_mask_t'(1) << barrier_warp) : '0;

	// walk the slots starting after the last issuer, wrapping back to it at the end
	always_comb begin
		warp_id_t cand;
		sel = last_q;
		sel_found = 1'b0;
		for (int i = 1; i <= num_warps; i++) begin
			cand = last_q + warp_id_t'(i);
			if (!sel_found && issuable[cand]) begin
				sel = cand;
				sel_found = 1'b1;
			end
		end
	end

	// nothing new leaves the table while the transfer unit holds scheduling
	assign issue_fire = sel_found && !pause_scheduling;

	always_ff @(posedge clk) begin
		if (reset) begin
			issue_valid <= 1'b0;
			last_q <= warp_id_t'(num_warps - 1);
		end else begin
			issue_valid <= issue_fire;
			if (issue_fire) begin
				last_q <= sel;
			end
		end
	end

	// the issue payload carries the PC before it is advanced
	always_ff @(posedge clk) begin
		if (issue_fire) begin
			issue_warp <= sel;
			issue_pc <= pc_q[sel];
		end
	end

	// a launch loads the slot and wins over an issue from the same slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < num_warps; i++) begin
			if (launch && launch_warp == warp_id_t'(i)) begin
				pc_q[i] <= launch_pc;
				mask_q[i] <= launch_mask;
			end else if (issue_fire && sel == warp_id_t'(i)) begin
				pc_q[i] <= pc_q[i] + inst_bytes;
			end
		end
	end

	// warps never exit here, so only reset clears the active bits
	// release frees every barrier, then a new arrival is applied on top of it
	// a freshly launched warp starts outside any barrier
	always_ff @(posedge clk) begin
		if (reset) begin
			active_q <= '0;
			barrier_q <= '0;
		end else begin
			active_q <= active_q | launch_onehot;
			barrier_q <= ((barrier_release ? '0 : barrier_q) | arrive_onehot) & ~launch_onehot;
		end
	end

	// diverge and reconverge together on one warp cancel out
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_warps; i++) begin
				depth_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < num_warps; i++) begin
				if (launch_onehot[i]) begin
					depth_q[i] <= '0;
				end else if (div_warp == warp_id_t'(i)) begin
					if (diverge && !reconverge && depth_q[i] != depth_max) begin
						depth_q[i] <= depth_q[i] + depth_t'(1);
					end else if (reconverge && !diverge && depth_q[i] != '0) begin
						depth_q[i] <= depth_q[i] - depth_t'(1);
					end
				end
			end
		end
	end

	// the transfer unit reads the raw slot state
	always_comb begin
		for (int i = 0; i < num_warps; i++) begin
			warp_stack_empty[i] = (depth_q[i] == '0);
			warp_pc[i] = pc_q[i];
			warp_mask[i] = mask_q[i];
		end
	end

	assign warp_active = active_q;
	assign warp_barriered = barrier_q;

endmodule
